// ==== csr_unit.f ====
hw/csr_pkg.sv
hw/csr_trap_ctrl.sv
hw/csr_timer.sv
hw/csr_config_regs.sv
hw/csr_read_mux.sv
hw/csr_unit.sv
verification/csr_unit_sva.sv
verification/csr_unit_tb.sv

// ==== hw/csr_config_regs.sv ====
module csr_config_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               csr_write_en,
    input  csr_pkg::csr_addr_t csr_write_addr,
    input  csr_pkg::csr_data_t csr_write_data,
    output csr_pkg::csr_data_t ecfg,
    output csr_pkg::csr_data_t eentry,
    output csr_pkg::csr_data_t save0,
    output csr_pkg::csr_data_t save1,
    output csr_pkg::csr_data_t save2,
    output csr_pkg::csr_data_t save3,
    output csr_pkg::csr_data_t tid
);
    import csr_pkg::*;

    csr_data_t save_q [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg   <= '0;
            eentry <= '0;
            tid    <= '0;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (csr_write_en) begin
            case (csr_write_addr)
                CSR_ECFG:   ecfg   <= masked_write(ecfg, csr_write_data, ECFG_WMASK);
                CSR_EENTRY: eentry <= masked_write(eentry, csr_write_data, EENTRY_WMASK);
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: begin
                    // SAVE block is 4-aligned, low bits pick the slot
                    save_q[csr_write_addr[1:0]] <= csr_write_data;
                end
                CSR_TID:    tid <= csr_write_data;
                default: ;
            endcase
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// ==== hw/csr_pkg.sv ====
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // CSR addresses
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECFG   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_BADV   = 14'h7;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_CPUID  = 14'h20;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_SAVE1  = 14'h31;
    localparam csr_addr_t CSR_SAVE2  = 14'h32;
    localparam csr_addr_t CSR_SAVE3  = 14'h33;
    localparam csr_addr_t CSR_TID    = 14'h40;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    // Software-writable bits
    localparam csr_data_t CRMD_WMASK   = 32'h0000_01ff;
    localparam csr_data_t PRMD_WMASK   = 32'h0000_0007;
    localparam csr_data_t ECFG_WMASK   = 32'h0000_1bff;
    localparam csr_data_t ESTAT_WMASK  = 32'h0000_0003;
    localparam csr_data_t EENTRY_WMASK = 32'hffff_ffc0;

    localparam csr_data_t CRMD_RESET = 32'h0000_0008;  // DA set

    localparam ecode_t ECODE_ADEF = 6'h8;
    localparam ecode_t ECODE_ALE  = 6'h9;

    // CRMD / PRMD fields
    localparam int PLV_LO = 0;
    localparam int PLV_HI = 1;
    localparam int IE_BIT = 2;

    // ESTAT fields
    localparam int ESTAT_HWI_LO  = 2;
    localparam int ESTAT_HWI_HI  = 9;
    localparam int ESTAT_TI      = 11;
    localparam int ECODE_LO      = 16;
    localparam int ECODE_HI      = 21;
    localparam int ESUBCODE_LO   = 22;
    localparam int ESUBCODE_HI   = 30;

    // TCFG fields
    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;

    localparam int HWI_W = 8;

    // Keeps unmasked bits of the old value
    function automatic csr_data_t masked_write(input csr_data_t old_val,
                                               input csr_data_t wdata,
                                               input csr_data_t mask);
        return (old_val & ~mask) | (wdata & mask);
    endfunction

endpackage

// ==== hw/csr_read_mux.sv ====
module csr_read_mux (
    input  logic               read_en0,
    input  csr_pkg::csr_addr_t read_addr0,
    output csr_pkg::csr_data_t read_data0,
    input  logic               read_en1,
    input  csr_pkg::csr_addr_t read_addr1,
    output csr_pkg::csr_data_t read_data1,
    input  csr_pkg::csr_data_t crmd,
    input  csr_pkg::csr_data_t prmd,
    input  csr_pkg::csr_data_t ecfg,
    input  csr_pkg::csr_data_t estat,
    input  csr_pkg::csr_data_t era,
    input  csr_pkg::csr_data_t badv,
    input  csr_pkg::csr_data_t eentry,
    input  csr_pkg::csr_data_t save0,
    input  csr_pkg::csr_data_t save1,
    input  csr_pkg::csr_data_t save2,
    input  csr_pkg::csr_data_t save3,
    input  csr_pkg::csr_data_t tid,
    input  csr_pkg::csr_data_t tcfg,
    input  csr_pkg::csr_data_t tval,
    input  logic               timer_pending
);
    import csr_pkg::*;

    csr_data_t estat_rd;

    // Timer bit taken straight from the timer
    always_comb begin
        estat_rd           = estat;
        estat_rd[ESTAT_TI] = timer_pending;
    end

    function automatic csr_data_t csr_lookup(input logic en, input csr_addr_t addr);
        csr_data_t val;
        val = '0;
        if (en) begin
            case (addr)
                CSR_CRMD:   val = crmd;
                CSR_PRMD:   val = prmd;
                CSR_ECFG:   val = ecfg;
                CSR_ESTAT:  val = estat_rd;
                CSR_ERA:    val = era;
                CSR_BADV:   val = badv;
                CSR_EENTRY: val = eentry;
                CSR_SAVE0:  val = save0;
                CSR_SAVE1:  val = save1;
                CSR_SAVE2:  val = save2;
                CSR_SAVE3:  val = save3;
                CSR_TID:    val = tid;
                CSR_TCFG:   val = tcfg;
                CSR_TVAL:   val = tval;
                CSR_CPUID, CSR_TICLR: val = '0;  // Single core, TICLR is write-only
                default:    val = '0;
            endcase
        end
        return val;
    endfunction

    // Ports decode on their own
    always_comb begin
        read_data0 = csr_lookup(read_en0, read_addr0);
        read_data1 = csr_lookup(read_en1, read_addr1);
    end

endmodule

// ==== hw/csr_timer.sv ====
module csr_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               csr_write_en,
    input  csr_pkg::csr_addr_t csr_write_addr,
    input  csr_pkg::csr_data_t csr_write_data,
    output csr_pkg::csr_data_t tcfg,
    output csr_pkg::csr_data_t tval,
    output logic               timer_pending
);
    import csr_pkg::*;

    logic      tcfg_wen;
    logic      ticlr_clr;
    logic      timer_en;
    logic      expire;
    csr_data_t reload_val;

    assign tcfg_wen  = csr_write_en && (csr_write_addr == CSR_TCFG);
    assign ticlr_clr = csr_write_en && (csr_write_addr == CSR_TICLR) && csr_write_data[0];
    assign expire    = timer_en && (tval == '0);

    // One-shot timers park at all ones
    assign reload_val = tcfg[TCFG_PERIODIC] ?
                        {tcfg[31:TCFG_INITVAL_LO], {TCFG_INITVAL_LO{1'b0}}} : '1;

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg <= '0;
        end else if (tcfg_wen) begin
            tcfg <= csr_write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tval <= '0;
        end else if (tcfg_wen) begin
            tval <= {csr_write_data[31:TCFG_INITVAL_LO], {TCFG_INITVAL_LO{1'b0}}};
        end else if (timer_en) begin
            if (tval != '0) begin
                tval <= tval - 1'b1;
            end else begin
                tval <= reload_val;
            end
        end
    end

    // Clear beats the TCFG enable update in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_en      <= 1'b0;
            timer_pending <= 1'b0;
        end else if (ticlr_clr) begin
            timer_pending <= 1'b0;
        end else if (tcfg_wen) begin
            timer_en <= csr_write_data[TCFG_EN];
        end else if (expire) begin
            timer_pending <= 1'b1;
            timer_en      <= tcfg[TCFG_PERIODIC];
        end
    end

endmodule

// ==== hw/csr_trap_ctrl.sv ====
module csr_trap_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      csr_write_en,
    input  csr_pkg::csr_addr_t        csr_write_addr,
    input  csr_pkg::csr_data_t        csr_write_data,
    input  logic                      is_exception,
    input  logic                      is_ertn,
    input  csr_pkg::ecode_t           ecode,
    input  csr_pkg::esubcode_t        esubcode,
    input  csr_pkg::csr_data_t        exception_pc,
    input  csr_pkg::csr_data_t        exception_addr,
    input  logic [csr_pkg::HWI_W-1:0] hwi,
    input  logic                      timer_pending,
    output csr_pkg::csr_data_t        crmd,
    output csr_pkg::csr_data_t        prmd,
    output csr_pkg::csr_data_t        era,
    output csr_pkg::csr_data_t        badv,
    output csr_pkg::csr_data_t        estat
);
    import csr_pkg::*;

    logic      crmd_wen;
    logic      prmd_wen;
    logic      estat_wen;
    logic      era_wen;
    logic      badv_wen;
    csr_data_t estat_q;

    assign crmd_wen  = csr_write_en && (csr_write_addr == CSR_CRMD);
    assign prmd_wen  = csr_write_en && (csr_write_addr == CSR_PRMD);
    assign estat_wen = csr_write_en && (csr_write_addr == CSR_ESTAT);
    assign era_wen   = csr_write_en && (csr_write_addr == CSR_ERA);
    assign badv_wen  = csr_write_en && (csr_write_addr == CSR_BADV);

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= CRMD_RESET;
        end else if (is_exception) begin
            crmd[PLV_HI:PLV_LO] <= '0;  // Enter kernel, interrupts off
            crmd[IE_BIT]        <= 1'b0;
        end else if (is_ertn) begin
            crmd[PLV_HI:PLV_LO] <= prmd[PLV_HI:PLV_LO];
            crmd[IE_BIT]        <= prmd[IE_BIT];
        end else if (crmd_wen) begin
            crmd <= masked_write(crmd, csr_write_data, CRMD_WMASK);
        end
    end

    // Ertn leaves PRMD alone, so a write still lands then
    always_ff @(posedge clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (is_exception) begin
            prmd[PLV_HI:PLV_LO] <= crmd[PLV_HI:PLV_LO];
            prmd[IE_BIT]        <= crmd[IE_BIT];
        end else if (prmd_wen) begin
            prmd <= masked_write(prmd, csr_write_data, PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era <= '0;
        end else if (is_exception) begin
            era <= exception_pc;
        end else if (era_wen) begin
            era <= csr_write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badv <= '0;
        end else if (is_exception) begin
            case (ecode)
                ECODE_ALE:  badv <= exception_addr;
                ECODE_ADEF: badv <= exception_pc;   // Fetch fault, PC is the bad address
                default:    badv <= badv;
            endcase
        end else if (badv_wen) begin
            badv <= csr_write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_q <= '0;
        end else begin
            if (is_exception) begin
                estat_q[ECODE_HI:ECODE_LO]       <= ecode;
                estat_q[ESUBCODE_HI:ESUBCODE_LO] <= esubcode;
            end else if (estat_wen) begin
                estat_q <= masked_write(estat_q, csr_write_data, ESTAT_WMASK);
            end
            // Must follow the masked write so the sample wins
            estat_q[ESTAT_HWI_HI:ESTAT_HWI_LO] <= hwi;
        end
    end

    always_comb begin
        estat           = estat_q;
        estat[ESTAT_TI] = timer_pending;  // Lives in the timer
    end

endmodule

// ==== hw/csr_unit.sv ====
module csr_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      csr_write_en,
    input  csr_pkg::csr_addr_t        csr_write_addr,
    input  csr_pkg::csr_data_t        csr_write_data,
    input  logic                      is_exception,
    input  logic                      is_ertn,
    input  csr_pkg::ecode_t           ecode,
    input  csr_pkg::esubcode_t        esubcode,
    input  csr_pkg::csr_data_t        exception_pc,
    input  csr_pkg::csr_data_t        exception_addr,
    input  logic [csr_pkg::HWI_W-1:0] hwi,
    input  logic                      read_en0,
    input  csr_pkg::csr_addr_t        read_addr0,
    output csr_pkg::csr_data_t        read_data0,
    input  logic                      read_en1,
    input  csr_pkg::csr_addr_t        read_addr1,
    output csr_pkg::csr_data_t        read_data1,
    output csr_pkg::csr_data_t        crmd,
    output csr_pkg::csr_data_t        era,
    output csr_pkg::csr_data_t        eentry,
    output csr_pkg::csr_data_t        ecfg,
    output csr_pkg::csr_data_t        estat
);
    import csr_pkg::*;

    csr_data_t prmd;
    csr_data_t badv;
    csr_data_t save0;
    csr_data_t save1;
    csr_data_t save2;
    csr_data_t save3;
    csr_data_t tid;
    csr_data_t tcfg;
    csr_data_t tval;
    logic      timer_pending;

    csr_trap_ctrl i_csr_trap_ctrl (
        .clk            (clk),
        .rst            (rst),
        .csr_write_en   (csr_write_en),
        .csr_write_addr (csr_write_addr),
        .csr_write_data (csr_write_data),
        .is_exception   (is_exception),
        .is_ertn        (is_ertn),
        .ecode          (ecode),
        .esubcode       (esubcode),
        .exception_pc   (exception_pc),
        .exception_addr (exception_addr),
        .hwi            (hwi),
        .timer_pending  (timer_pending),
        .crmd           (crmd),
        .prmd           (prmd),
        .era            (era),
        .badv           (badv),
        .estat          (estat)
    );

    csr_timer i_csr_timer (
        .clk            (clk),
        .rst            (rst),
        .csr_write_en   (csr_write_en),
        .csr_write_addr (csr_write_addr),
        .csr_write_data (csr_write_data),
        .tcfg           (tcfg),
        .tval           (tval),
        .timer_pending  (timer_pending)
    );

    csr_config_regs i_csr_config_regs (
        .clk            (clk),
        .rst            (rst),
        .csr_write_en   (csr_write_en),
        .csr_write_addr (csr_write_addr),
        .csr_write_data (csr_write_data),
        .ecfg           (ecfg),
        .eentry         (eentry),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3),
        .tid            (tid)
    );

    csr_read_mux i_csr_read_mux (
        .read_en0      (read_en0),
        .read_addr0    (read_addr0),
        .read_data0    (read_data0),
        .read_en1      (read_en1),
        .read_addr1    (read_addr1),
        .read_data1    (read_data1),
        .crmd          (crmd),
        .prmd          (prmd),
        .ecfg          (ecfg),
        .estat         (estat),
        .era           (era),
        .badv          (badv),
        .eentry        (eentry),
        .save0         (save0),
        .save1         (save1),
        .save2         (save2),
        .save3         (save3),
        .tid           (tid),
        .tcfg          (tcfg),
        .tval          (tval),
        .timer_pending (timer_pending)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module csr_unit_tb -Mdir obj_dir -f csr_unit.f \
    || { echo "BUILD FAILED"; exit 1; }
out=$(./obj_dir/Vcsr_unit_tb)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "SIMULATION PASSED" \
    || { echo "SIMULATION FAILED"; exit 1; }

// ==== verification/csr_unit_sva.sv ====
module csr_unit_sva (
    input logic               clk,
    input logic               rst,
    input logic               read_en0,
    input csr_pkg::csr_data_t read_data0,
    input logic               read_en1,
    input csr_pkg::csr_data_t read_data1,
    input logic               is_exception,
    input csr_pkg::csr_data_t exception_pc,
    input csr_pkg::csr_data_t crmd,
    input csr_pkg::csr_data_t era
);
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    a_rd0_idle: assert property (@(posedge clk) disable iff (rst)
        !read_en0 |-> read_data0 == '0)
        else $error("read_data0 not zero while read_en0 is low");

    a_rd1_idle: assert property (@(posedge clk) disable iff (rst)
        !read_en1 |-> read_data1 == '0)
        else $error("read_data1 not zero while read_en1 is low");

    // Kernel mode, interrupts off after entry
    a_exc_crmd: assert property (@(posedge clk) disable iff (rst)
        is_exception |=> (crmd[PLV_HI:PLV_LO] == '0) && !crmd[IE_BIT])
        else $error("CRMD PLV/IE not cleared after exception");

    a_exc_era: assert property (@(posedge clk) disable iff (rst)
        is_exception |=> era == $past(exception_pc))
        else $error("ERA does not hold the exception PC");

endmodule

bind csr_unit csr_unit_sva i_csr_unit_sva (.*);

// ==== verification/csr_unit_tb.sv ====
module csr_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int LEN_RESET    = 8;
    localparam int LEN_WRITE    = 600;
    localparam int LEN_TRAP     = 600;
    localparam int LEN_BADV     = 250;
    localparam int LEN_TIMER    = 400;
    localparam int LEN_ZERO     = 250;
    localparam int RUN_CYCLES   = RESET_CYCLES + LEN_RESET + LEN_WRITE + LEN_TRAP + LEN_BADV
                                  + 2 * LEN_TIMER + LEN_ZERO;
    localparam int CYCLE_LIMIT  = RUN_CYCLES * 11 / 10;

    localparam int MODE_RESET    = 0;
    localparam int MODE_WRITE    = 1;
    localparam int MODE_TRAP     = 2;
    localparam int MODE_BADV     = 3;
    localparam int MODE_ONESHOT  = 4;
    localparam int MODE_PERIODIC = 5;
    localparam int MODE_ZERO     = 6;

    localparam csr_data_t TRAP_BITS = 32'h0000_0007;  // PLV and IE

    logic               clk = 1'b0;
    logic               rst;
    logic               csr_write_en;
    csr_addr_t          csr_write_addr;
    csr_data_t          csr_write_data;
    logic               is_exception;
    logic               is_ertn;
    ecode_t             ecode;
    esubcode_t          esubcode;
    csr_data_t          exception_pc;
    csr_data_t          exception_addr;
    logic [HWI_W-1:0]   hwi;
    logic               read_en0;
    csr_addr_t          read_addr0;
    csr_data_t          read_data0;
    logic               read_en1;
    csr_addr_t          read_addr1;
    csr_data_t          read_data1;
    csr_data_t          crmd;
    csr_data_t          era;
    csr_data_t          eentry;
    csr_data_t          ecfg;
    csr_data_t          estat;

    // Reference model state
    csr_data_t m_crmd, m_prmd, m_era, m_badv, m_estat, m_ecfg, m_eentry, m_tid;
    csr_data_t m_tcfg, m_tval;
    csr_data_t m_save [4];
    logic      m_ten, m_tpend;

    integer seed = 32'hcdde_5f75;
    int     cycle_count;
    int     test_errors;
    int     total_errors = 0;
    int     tests_run = 0;
    int     tests_bad = 0;

    csr_addr_t map_addrs [16] = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_ECFG,
                                  CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                                  CSR_TID, CSR_TCFG, CSR_TVAL, CSR_CPUID, CSR_TICLR};

    csr_unit i_csr_unit (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [3:0] pick(input logic [31:0] n);
        return 4'(rnd() % n);
    endfunction

    function automatic logic write_hits(input csr_addr_t addr);
        return csr_write_en && (csr_write_addr == addr);
    endfunction

    function automatic csr_data_t model_estat();
        csr_data_t val;
        val     = m_estat;
        val[11] = m_tpend;
        return val;
    endfunction

    function automatic csr_data_t model_read(input logic en, input csr_addr_t addr);
        if (!en) return '0;
        case (addr)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ECFG:   return m_ecfg;
            CSR_ESTAT:  return model_estat();
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0:  return m_save[0];
            CSR_SAVE1:  return m_save[1];
            CSR_SAVE2:  return m_save[2];
            CSR_SAVE3:  return m_save[3];
            CSR_TID:    return m_tid;
            CSR_TCFG:   return m_tcfg;
            CSR_TVAL:   return m_tval;
            default:    return '0;  // CPUID, TICLR, holes
        endcase
    endfunction

    task automatic model_reset();
        m_crmd   = CRMD_RESET;
        m_prmd   = '0;
        m_era    = '0;
        m_badv   = '0;
        m_estat  = '0;
        m_ecfg   = '0;
        m_eentry = '0;
        m_tid    = '0;
        m_tcfg   = '0;
        m_tval   = '0;
        m_save   = '{default: '0};
        m_ten    = 1'b0;
        m_tpend  = 1'b0;
    endtask

    // One rising edge of the reference model
    task automatic model_step();
        csr_data_t old_crmd;
        logic      clr;
        logic      tcfg_wr;
        logic      expire;
        old_crmd = m_crmd;
        if (is_exception) begin
            m_crmd         = m_crmd & ~TRAP_BITS;
            m_prmd         = (m_prmd & ~TRAP_BITS) | (old_crmd & TRAP_BITS);
            m_era          = exception_pc;
            m_estat[21:16] = ecode;
            m_estat[30:22] = esubcode;
            if (ecode == ECODE_ALE) m_badv = exception_addr;
            else if (ecode == ECODE_ADEF) m_badv = exception_pc;
        end else begin
            if (is_ertn) m_crmd = (m_crmd & ~TRAP_BITS) | (m_prmd & TRAP_BITS);
            else if (write_hits(CSR_CRMD))
                m_crmd = (m_crmd & ~CRMD_WMASK) | (csr_write_data & CRMD_WMASK);
            if (write_hits(CSR_PRMD))
                m_prmd = (m_prmd & ~PRMD_WMASK) | (csr_write_data & PRMD_WMASK);
            if (write_hits(CSR_ERA)) m_era = csr_write_data;
            if (write_hits(CSR_BADV)) m_badv = csr_write_data;
            if (write_hits(CSR_ESTAT)) m_estat[1:0] = csr_write_data[1:0];
        end
        m_estat[9:2] = hwi;
        if (csr_write_en) begin
            case (csr_write_addr)
                CSR_ECFG:   m_ecfg = (m_ecfg & ~ECFG_WMASK) | (csr_write_data & ECFG_WMASK);
                CSR_EENTRY: m_eentry = (m_eentry & ~EENTRY_WMASK) | (csr_write_data & EENTRY_WMASK);
                CSR_SAVE0:  m_save[0] = csr_write_data;
                CSR_SAVE1:  m_save[1] = csr_write_data;
                CSR_SAVE2:  m_save[2] = csr_write_data;
                CSR_SAVE3:  m_save[3] = csr_write_data;
                CSR_TID:    m_tid = csr_write_data;
                default: ;
            endcase
        end
        clr     = write_hits(CSR_TICLR) && csr_write_data[0];
        tcfg_wr = write_hits(CSR_TCFG);
        expire  = m_ten && (m_tval == '0);
        if (tcfg_wr) m_tval = {csr_write_data[31:2], 2'b00};
        else if (m_ten && (m_tval != '0)) m_tval = m_tval - 32'd1;
        else if (expire) m_tval = m_tcfg[1] ? {m_tcfg[31:2], 2'b00} : '1;
        if (clr) begin
            m_tpend = 1'b0;
        end else if (tcfg_wr) begin
            m_ten = csr_write_data[0];
        end else if (expire) begin
            m_tpend = 1'b1;
            m_ten   = m_tcfg[1];
        end
        if (tcfg_wr) m_tcfg = csr_write_data;
    endtask

    task automatic compare_data(input string name, input csr_data_t exp, input csr_data_t act);
        if (act !== exp) begin
            test_errors++;
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic compare_read(input string name, input csr_addr_t addr,
                                input csr_data_t exp, input csr_data_t act);
        if (act !== exp) begin
            test_errors++;
            $display("ERROR %s at addr 0x%h: expected 0x%h, got 0x%h", name, addr, exp, act);
        end
    endtask

    task automatic check_outputs();
        compare_read("read_data0", read_addr0, model_read(read_en0, read_addr0), read_data0);
        compare_read("read_data1", read_addr1, model_read(read_en1, read_addr1), read_data1);
        compare_data("crmd", m_crmd, crmd);
        compare_data("era", m_era, era);
        compare_data("eentry", m_eentry, eentry);
        compare_data("ecfg", m_ecfg, ecfg);
        compare_data("estat", model_estat(), estat);
    endtask

    task automatic drive_inputs(input int mode, input int i);
        logic [1:0] sel;
        sel            = 2'(rnd() % 3);
        csr_write_en   = 1'b0;
        csr_write_addr = map_addrs[pick(16)];
        csr_write_data = rnd();
        is_exception   = 1'b0;
        is_ertn        = 1'b0;
        ecode          = (sel == 2'd0) ? ECODE_ALE : (sel == 2'd1) ? ECODE_ADEF : 6'(rnd());
        esubcode       = 9'(rnd());
        exception_pc   = rnd();
        exception_addr = rnd();
        hwi            = (mode == MODE_RESET) ? '0 : 8'(rnd());
        read_en0       = (rnd() % 8) != 0;
        read_addr0     = map_addrs[pick(16)];
        read_en1       = (rnd() % 8) != 0;
        read_addr1     = map_addrs[pick(16)];
        case (mode)
            MODE_RESET: begin
                read_en0   = 1'b1;
                read_en1   = 1'b1;
                read_addr0 = map_addrs[4'(2 * i)];
                read_addr1 = map_addrs[4'(2 * i + 1)];
            end
            MODE_WRITE: begin
                csr_write_en   = (rnd() % 5) < 3;
                csr_write_addr = map_addrs[pick(12)];  // Timer kept out
            end
            MODE_TRAP: begin
                csr_write_en   = (rnd() % 2) == 0;
                csr_write_addr = map_addrs[pick(7)];
                is_exception   = (rnd() % 4) == 0;
                is_ertn        = (rnd() % 4) == 0;
            end
            MODE_BADV: begin
                csr_write_en   = (rnd() % 10) < 3;
                csr_write_addr = map_addrs[pick(5)];
                is_exception   = (rnd() % 2) == 0;
            end
            MODE_ONESHOT, MODE_PERIODIC: begin
                read_en0   = 1'b1;
                read_addr0 = CSR_TVAL;
                read_en1   = 1'b1;
                read_addr1 = CSR_ESTAT;
                if (i % 200 == 0) begin
                    // Short count so it expires before the next re-arm
                    csr_write_en   = 1'b1;
                    csr_write_addr = CSR_TCFG;
                    csr_write_data = {30'(rnd() % 40 + 4), mode == MODE_PERIODIC, 1'b1};
                end else if (rnd() % 32 == 0) begin
                    csr_write_en   = 1'b1;
                    csr_write_addr = CSR_TICLR;
                end
            end
            MODE_ZERO: begin
                read_addr0 = (sel == 2'd0) ? CSR_CPUID : (sel == 2'd1) ? CSR_TICLR : 14'(rnd());
                read_addr1 = ((rnd() % 2) == 0) ? CSR_ESTAT : map_addrs[pick(16)];
            end
            default: ;
        endcase
    endtask

    task automatic run_test(input string name, input int mode, input int n);
        test_errors = 0;
        for (int i = 0; i < n; i++) begin
            drive_inputs(mode, i);
            #4;
            check_outputs();  // Just before the rising edge
            @(posedge clk);
            model_step();
            @(negedge clk);
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) tests_bad++;
        $display("%-10s %0d cycles, %0d mismatches", name, n, test_errors);
    endtask

    initial begin
        rst            = 1'b1;
        csr_write_en   = 1'b0;
        csr_write_addr = '0;
        csr_write_data = '0;
        is_exception   = 1'b0;
        is_ertn        = 1'b0;
        ecode          = '0;
        esubcode       = '0;
        exception_pc   = '0;
        exception_addr = '0;
        hwi            = '0;
        read_en0       = 1'b0;
        read_addr0     = '0;
        read_en1       = 1'b0;
        read_addr1     = '0;
        model_reset();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        run_test("reset", MODE_RESET, LEN_RESET);
        run_test("writes", MODE_WRITE, LEN_WRITE);
        run_test("trap", MODE_TRAP, LEN_TRAP);
        run_test("badv", MODE_BADV, LEN_BADV);
        run_test("oneshot", MODE_ONESHOT, LEN_TIMER);
        run_test("periodic", MODE_PERIODIC, LEN_TIMER);
        run_test("zero_read", MODE_ZERO, LEN_ZERO);
        $display("Summary: %0d tests, %0d with mismatches, %0d mismatches in total",
                 tests_run, tests_bad, total_errors);
        if (tests_bad == 0) $display("all tests passed");
        else $display("tests failed");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("tests failed");
        $finish;
    end

endmodule
